// File: compile.f
rvc_pkg.sv
rvc_classifier.sv
rvc_reg_map.sv
rvc_imm_gen.sv
rvc_encoder.sv
rvc_expander.sv
tb_rvc_expander.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rvc_expander \
    -f compile.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && grep -F -q '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: rvc_classifier.sv
`timescale 1ns/1ps

module rvc_classifier import rvc_pkg::*; (
    input  cinstr_t     cinstr_i,
    output rvc_fields_t fields_o
);

    logic [1:0] quad;
    logic [2:0] funct3;
    reg_idx_t   rd_full;
    reg_idx_t   rs2_full;
    logic       ci_imm_zero;
    rvc_op_e    op;

    assign quad        = cinstr_i[1:0];
    assign funct3      = cinstr_i[15:13];
    assign rd_full     = cinstr_i[11:7];
    assign rs2_full    = cinstr_i[6:2];
    assign ci_imm_zero = ({cinstr_i[12], cinstr_i[6:2]} == 6'd0);

    always_comb begin
        op = OP_ILLEGAL;

        case (quad)
            // ==================================================
            // quadrant 0
            // ==================================================
            2'b00: begin
                case (funct3)
                    // nzuimm lives in bits 12:5, also catches the all-zero word
                    3'b000: op = (cinstr_i[12:5] != 8'd0) ? OP_ADDI4SPN : OP_ILLEGAL;
                    3'b010: op = OP_LW;
                    3'b110: op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end

            // ==================================================
            // quadrant 1
            // ==================================================
            2'b01: begin
                case (funct3)
                    3'b000: op = (rd_full == REG_ZERO) ? OP_NOP : OP_ADDI;
                    3'b001: op = OP_JAL;
                    3'b010: op = OP_LI;
                    3'b011: begin
                        if (rd_full == REG_SP) begin
                            op = ci_imm_zero ? OP_ILLEGAL : OP_ADDI16SP;
                        end else if (rd_full == REG_ZERO || ci_imm_zero) begin
                            op = OP_ILLEGAL;
                        end else begin
                            op = OP_LUI;
                        end
                    end
                    3'b100: begin
                        case (cinstr_i[11:10])
                            // shamt[5] must be clear on RV32
                            2'b00: op = cinstr_i[12] ? OP_ILLEGAL : OP_SRLI;
                            2'b01: op = cinstr_i[12] ? OP_ILLEGAL : OP_SRAI;
                            2'b10: op = OP_ANDI;
                            default: begin
                                if (cinstr_i[12]) begin
                                    op = OP_ILLEGAL;
                                end else begin
                                    case (cinstr_i[6:5])
                                        2'b00: op = OP_SUB;
                                        2'b01: op = OP_XOR;
                                        2'b10: op = OP_OR;
                                        default: op = OP_AND;
                                    endcase
                                end
                            end
                        endcase
                    end
                    3'b101: op = OP_J;
                    3'b110: op = OP_BEQZ;
                    default: op = OP_BNEZ;
                endcase
            end

            // ==================================================
            // quadrant 2
            // ==================================================
            2'b10: begin
                case (funct3)
                    3'b000: op = cinstr_i[12] ? OP_ILLEGAL : OP_SLLI;
                    3'b010: op = (rd_full == REG_ZERO) ? OP_ILLEGAL : OP_LWSP;
                    3'b110: op = OP_SWSP;
                    3'b100: begin
                        if (!cinstr_i[12]) begin
                            if (rs2_full != REG_ZERO) begin
                                op = OP_MV;
                            end else begin
                                op = (rd_full == REG_ZERO) ? OP_ILLEGAL : OP_JR;
                            end
                        end else if (rs2_full != REG_ZERO) begin
                            op = OP_ADD;
                        end else begin
                            // rs1 = x0 here is the ebreak word, not supported
                            op = (rd_full == REG_ZERO) ? OP_ILLEGAL : OP_JALR;
                        end
                    end
                    default: op = OP_ILLEGAL;
                endcase
            end

            // low bits 11 mean an uncompressed word
            default: op = OP_ILLEGAL;
        endcase
    end

    assign fields_o.op      = op;
    assign fields_o.illegal = (op == OP_ILLEGAL);

endmodule

// File: rvc_encoder.sv
`timescale 1ns/1ps

module rvc_encoder import rvc_pkg::*; (
    input  rvc_fields_t     fields_i,
    input  rvc_regs_t       regs_i,
    input  logic [ILEN-1:0] imm_i,
    output instr_t          instr_o
);

    typedef enum logic [2:0] {
        FMT_I,
        FMT_SH,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_R
    } fmt_e;

    fmt_e       fmt;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    instr_t     word;

    always_comb begin
        fmt = FMT_R;
        opc = '0;
        f3  = '0;
        f7  = '0;

        case (fields_i.op)
            OP_ADDI4SPN, OP_NOP, OP_ADDI, OP_LI, OP_ADDI16SP: begin
                fmt = FMT_I; opc = OPC_OP_IMM; f3 = F3_ADD;
            end
            OP_ANDI:          begin fmt = FMT_I;  opc = OPC_OP_IMM; f3 = F3_AND; end
            OP_LW, OP_LWSP:   begin fmt = FMT_I;  opc = OPC_LOAD;   f3 = F3_LW;  end
            OP_SW, OP_SWSP:   begin fmt = FMT_S;  opc = OPC_STORE;  f3 = F3_LW;  end
            OP_JR, OP_JALR:   begin fmt = FMT_I;  opc = OPC_JALR;   f3 = F3_ADD; end
            OP_J, OP_JAL:     begin fmt = FMT_J;  opc = OPC_JAL;                 end
            OP_LUI:           begin fmt = FMT_U;  opc = OPC_LUI;                 end
            OP_BEQZ:          begin fmt = FMT_B;  opc = OPC_BRANCH; f3 = F3_BEQ; end
            OP_BNEZ:          begin fmt = FMT_B;  opc = OPC_BRANCH; f3 = F3_BNE; end
            OP_SLLI:          begin fmt = FMT_SH; opc = OPC_OP_IMM; f3 = F3_SLL; end
            OP_SRLI:          begin fmt = FMT_SH; opc = OPC_OP_IMM; f3 = F3_SRL; end
            OP_SRAI: begin
                fmt = FMT_SH; opc = OPC_OP_IMM; f3 = F3_SRL; f7 = F7_ALT;
            end
            OP_SUB:           begin opc = OPC_OP; f3 = F3_ADD; f7 = F7_ALT; end
            OP_XOR:           begin opc = OPC_OP; f3 = F3_XOR; end
            OP_OR:            begin opc = OPC_OP; f3 = F3_OR;  end
            OP_AND:           begin opc = OPC_OP; f3 = F3_AND; end
            OP_MV, OP_ADD:    begin opc = OPC_OP; f3 = F3_ADD; end
            default: ;
        endcase
    end

    // ==================================================
    // format packing
    // ==================================================

    always_comb begin
        case (fmt)
            FMT_I:  word = {imm_i[11:0], regs_i.rs1, f3, regs_i.rd, opc};
            FMT_SH: word = {f7, imm_i[4:0], regs_i.rs1, f3, regs_i.rd, opc};
            FMT_S:  word = {imm_i[11:5], regs_i.rs2, regs_i.rs1, f3, imm_i[4:0], opc};
            FMT_B:  word = {imm_i[12], imm_i[10:5], regs_i.rs2, regs_i.rs1, f3,
                            imm_i[4:1], imm_i[11], opc};
            FMT_U:  word = {imm_i[31:12], regs_i.rd, opc};
            FMT_J:  word = {imm_i[20], imm_i[10:1], imm_i[11], imm_i[19:12],
                            regs_i.rd, opc};
            default: word = {f7, regs_i.rs2, regs_i.rs1, f3, regs_i.rd, opc};
        endcase
    end

    // every base instruction ends in 11
    assign instr_o = {word[ILEN-1:2], 2'b11};

endmodule

// File: rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander import rvc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        valid_i,
    output logic        ready_o,
    input  cinstr_t     cinstr_i,
    output logic        valid_o,
    input  logic        ready_i,
    output rvc_result_t result_o
);

    rvc_fields_t     fields;
    rvc_regs_t       regs;
    logic [ILEN-1:0] imm;
    instr_t          instr;
    rvc_result_t     result_d;
    rvc_result_t     result_q;
    logic            valid_q;
    logic            accept;

    // ==================================================
    // decode datapath
    // ==================================================

    rvc_classifier u_classifier (
        .cinstr_i (cinstr_i),
        .fields_o (fields)
    );

    rvc_reg_map u_reg_map (
        .cinstr_i (cinstr_i),
        .fields_i (fields),
        .regs_o   (regs)
    );

    rvc_imm_gen u_imm_gen (
        .cinstr_i (cinstr_i),
        .fields_i (fields),
        .imm_o    (imm)
    );

    rvc_encoder u_encoder (
        .fields_i (fields),
        .regs_i   (regs),
        .imm_i    (imm),
        .instr_o  (instr)
    );

    assign result_d.instr   = instr;
    assign result_d.illegal = fields.illegal;

    // ==================================================
    // output stage
    // ==================================================

    // the stage frees up in the same cycle its item leaves
    assign ready_o = !valid_q || ready_i;
    assign accept  = valid_i && ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            result_q <= '0;
        end else begin
            if (ready_o) begin
                valid_q <= valid_i;
            end
            if (accept) begin
                result_q <= result_d;
            end
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

endmodule

// File: rvc_imm_gen.sv
`timescale 1ns/1ps

module rvc_imm_gen import rvc_pkg::*; (
    input  cinstr_t         cinstr_i,
    input  rvc_fields_t     fields_i,
    output logic [ILEN-1:0] imm_o
);

    logic            s;
    logic [ILEN-1:0] imm_ci;
    logic [ILEN-1:0] imm_addi4spn;
    logic [ILEN-1:0] imm_lw;
    logic [ILEN-1:0] imm_lwsp;
    logic [ILEN-1:0] imm_swsp;
    logic [ILEN-1:0] imm_addi16sp;
    logic [ILEN-1:0] imm_lui;
    logic [ILEN-1:0] imm_shamt;
    logic [ILEN-1:0] imm_jump;
    logic [ILEN-1:0] imm_branch;

    // bit 12 is the sign for every signed compressed immediate
    assign s = cinstr_i[12];

    // ==================================================
    // zero-extended offsets
    // ==================================================

    // nzuimm[9:6|5:4|3|2]
    assign imm_addi4spn = {22'd0, cinstr_i[10:7], cinstr_i[12:11],
                           cinstr_i[5], cinstr_i[6], 2'b00};

    // uimm[6|5:3|2], shared by c.lw and c.sw
    assign imm_lw = {25'd0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00};

    // uimm[7:6|5|4:2]
    assign imm_lwsp = {24'd0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00};

    // uimm[7:6|5:2]
    assign imm_swsp = {24'd0, cinstr_i[8:7], cinstr_i[12:9], 2'b00};

    assign imm_shamt = {27'd0, cinstr_i[6:2]};

    // ==================================================
    // sign-extended values
    // ==================================================

    assign imm_ci = {{26{s}}, s, cinstr_i[6:2]};

    // nzimm[9|8:7|6|5|4], scaled by 16
    assign imm_addi16sp = {{22{s}}, s, cinstr_i[4:3], cinstr_i[5],
                           cinstr_i[2], cinstr_i[6], 4'b0000};

    // nzimm[17:12] lands in the upper immediate
    assign imm_lui = {{14{s}}, s, cinstr_i[6:2], 12'd0};

    // offset[11|10|9:8|7|6|5|4|3:1]
    assign imm_jump = {{20{s}}, s, cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                       cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3], 1'b0};

    // offset[8|7:6|5|4:3|2:1]
    assign imm_branch = {{23{s}}, s, cinstr_i[6:5], cinstr_i[2],
                         cinstr_i[11:10], cinstr_i[4:3], 1'b0};

    always_comb begin
        case (fields_i.op)
            OP_ADDI4SPN:                    imm_o = imm_addi4spn;
            OP_LW, OP_SW:                   imm_o = imm_lw;
            OP_LWSP:                        imm_o = imm_lwsp;
            OP_SWSP:                        imm_o = imm_swsp;
            OP_NOP, OP_ADDI, OP_LI, OP_ANDI: imm_o = imm_ci;
            OP_ADDI16SP:                    imm_o = imm_addi16sp;
            OP_LUI:                         imm_o = imm_lui;
            OP_SRLI, OP_SRAI, OP_SLLI:      imm_o = imm_shamt;
            OP_J, OP_JAL:                   imm_o = imm_jump;
            OP_BEQZ, OP_BNEZ:               imm_o = imm_branch;
            // register forms and jr/jalr carry no immediate
            default:                        imm_o = '0;
        endcase
    end

endmodule

// File: rvc_pkg.sv
package rvc_pkg;

    // ==================================================
    // widths
    // ==================================================

    localparam int CINSTR_W = 16;
    localparam int ILEN     = 32;
    localparam int REG_W    = 5;

    typedef logic [CINSTR_W-1:0] cinstr_t;
    typedef logic [ILEN-1:0]     instr_t;
    typedef logic [REG_W-1:0]    reg_idx_t;

    // ==================================================
    // base ISA encodings
    // ==================================================

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 for SUB and SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    localparam reg_idx_t REG_ZERO  = 5'd0;
    localparam reg_idx_t REG_RA    = 5'd1;
    localparam reg_idx_t REG_SP    = 5'd2;
    // 3-bit register fields address x8..x15
    localparam reg_idx_t REG_CBASE = 5'd8;

    // ==================================================
    // decoded operation
    // ==================================================

    typedef enum logic [4:0] {
        OP_ADDI4SPN,
        OP_LW,
        OP_SW,
        OP_NOP,
        OP_ADDI,
        OP_JAL,
        OP_LI,
        OP_ADDI16SP,
        OP_LUI,
        OP_SRLI,
        OP_SRAI,
        OP_ANDI,
        OP_SUB,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_J,
        OP_BEQZ,
        OP_BNEZ,
        OP_SLLI,
        OP_LWSP,
        OP_SWSP,
        OP_JR,
        OP_JALR,
        OP_MV,
        OP_ADD,
        OP_ILLEGAL
    } rvc_op_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rvc_regs_t;

    typedef struct packed {
        rvc_op_e op;
        logic    illegal;
    } rvc_fields_t;

    typedef struct packed {
        instr_t instr;
        logic   illegal;
    } rvc_result_t;

endpackage

// File: rvc_reg_map.sv
`timescale 1ns/1ps

module rvc_reg_map import rvc_pkg::*; (
    input  cinstr_t     cinstr_i,
    input  rvc_fields_t fields_i,
    output rvc_regs_t   regs_o
);

    reg_idx_t r_full_a;
    reg_idx_t r_full_b;
    reg_idx_t r_comp_a;
    reg_idx_t r_comp_b;

    assign r_full_a = cinstr_i[11:7];
    assign r_full_b = cinstr_i[6:2];
    assign r_comp_a = REG_CBASE | {2'b00, cinstr_i[9:7]};
    assign r_comp_b = REG_CBASE | {2'b00, cinstr_i[4:2]};

    always_comb begin
        regs_o = '0;

        case (fields_i.op)
            OP_ADDI4SPN: begin
                regs_o.rd  = r_comp_b;
                regs_o.rs1 = REG_SP;
            end
            OP_LW: begin
                regs_o.rd  = r_comp_b;
                regs_o.rs1 = r_comp_a;
            end
            OP_SW: begin
                regs_o.rs1 = r_comp_a;
                regs_o.rs2 = r_comp_b;
            end
            OP_NOP, OP_ADDI, OP_SLLI: begin
                regs_o.rd  = r_full_a;
                regs_o.rs1 = r_full_a;
            end
            OP_JAL:  regs_o.rd = REG_RA;
            OP_J:    regs_o.rd = REG_ZERO;
            OP_LI: begin
                regs_o.rd  = r_full_a;
                regs_o.rs1 = REG_ZERO;
            end
            OP_ADDI16SP: begin
                regs_o.rd  = REG_SP;
                regs_o.rs1 = REG_SP;
            end
            OP_LUI:  regs_o.rd = r_full_a;
            OP_SRLI, OP_SRAI, OP_ANDI: begin
                regs_o.rd  = r_comp_a;
                regs_o.rs1 = r_comp_a;
            end
            OP_SUB, OP_XOR, OP_OR, OP_AND: begin
                regs_o.rd  = r_comp_a;
                regs_o.rs1 = r_comp_a;
                regs_o.rs2 = r_comp_b;
            end
            OP_BEQZ, OP_BNEZ: begin
                regs_o.rs1 = r_comp_a;
                regs_o.rs2 = REG_ZERO;
            end
            OP_LWSP: begin
                regs_o.rd  = r_full_a;
                regs_o.rs1 = REG_SP;
            end
            OP_SWSP: begin
                regs_o.rs1 = REG_SP;
                regs_o.rs2 = r_full_b;
            end
            OP_JR: begin
                regs_o.rd  = REG_ZERO;
                regs_o.rs1 = r_full_a;
            end
            OP_JALR: begin
                regs_o.rd  = REG_RA;
                regs_o.rs1 = r_full_a;
            end
            OP_MV: begin
                regs_o.rd  = r_full_a;
                regs_o.rs1 = REG_ZERO;
                regs_o.rs2 = r_full_b;
            end
            OP_ADD: begin
                regs_o.rd  = r_full_a;
                regs_o.rs1 = r_full_a;
                regs_o.rs2 = r_full_b;
            end
            default: regs_o = '0;
        endcase
    end

endmodule

// File: tb_rvc_expander.sv
`timescale 1ns/1ps

module tb_rvc_expander import rvc_pkg::*; ();

    localparam int N_Q0    = 200;
    localparam int N_Q1A   = 300;
    localparam int N_Q1C   = 200;
    localparam int N_Q2    = 300;
    localparam int N_Q3    = 100;
    localparam int N_BP    = 300;
    // random words plus the directed ones pushed before each test
    localparam int N_TOTAL = N_Q0 + N_Q1A + N_Q1C + N_Q2 + N_Q3 + N_BP + 7;
    localparam int TIMEOUT = 2 * N_TOTAL + 16 + 6 * 10;

    logic        clk;
    logic        rst_n_i;
    logic        valid_i;
    logic        ready_o;
    cinstr_t     cinstr_i;
    logic        valid_o;
    logic        ready_i;
    rvc_result_t result_o;

    logic [31:0] lfsr = 32'hb4fa_3405;
    int          cycle = 0;
    cinstr_t     pend_q[$];
    cinstr_t     sent_q[$];
    int          acc_cyc_q[$];
    string       cur_name = "reset";
    int          mon_err = 0;
    int          drv_err = 0;
    int          hs_err = 0;
    int          out_cnt = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic        prev_valid = 1'b0;
    logic        prev_ready = 1'b0;
    rvc_result_t prev_result = '0;

    rvc_expander DUT (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .cinstr_i (cinstr_i),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int error_total();
        return mon_err + drv_err + hs_err;
    endfunction

    // ==================================================
    // random source
    // ==================================================

    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < 16; i++) begin
            v = {v[14:0], rand_bit()};
        end
        return v;
    endfunction

    // the rest of each word stays random around the forced quadrant and funct3
    function automatic logic [15:0] gen_word(input int kind);
        logic [15:0] w;
        logic [1:0]  sel;
        w = rand_word();
        sel = {rand_bit(), rand_bit()};
        case (kind)
            1: w[1:0] = 2'b00;
            2: begin
                w[1:0] = 2'b01;
                case (sel)
                    2'd0: w[15:13] = 3'b000;
                    2'd1: w[15:13] = 3'b010;
                    2'd2: w[15:13] = 3'b011;
                    default: w[15:13] = 3'b100;
                endcase
                // steer some of the 011 words to c.addi16sp
                if (w[15:13] == 3'b011 && rand_bit()) begin
                    w[11:7] = 5'd2;
                end
            end
            3: begin
                w[1:0] = 2'b01;
                case (sel)
                    2'd0: w[15:13] = 3'b001;
                    2'd1: w[15:13] = 3'b101;
                    2'd2: w[15:13] = 3'b110;
                    default: w[15:13] = 3'b111;
                endcase
            end
            4: w[1:0] = 2'b10;
            5: w[1:0] = 2'b11;
            default: ;
        endcase
        return w;
    endfunction

    // ==================================================
    // reference model
    // ==================================================

    function automatic logic [31:0] pack_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] pack_s(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] pack_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rvc_result_t expand_model(input logic [15:0] c);
        rvc_result_t r;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs2p;
        logic [11:0] ci;
        logic [11:0] off;
        logic [8:0]  boff;
        logic [9:0]  sp16;
        logic [2:0]  f3;
        rd   = c[11:7];
        rs2  = c[6:2];
        rdp  = {2'b01, c[9:7]};
        rs2p = {2'b01, c[4:2]};
        ci   = {{7{c[12]}}, c[6:2]};
        r    = '0;
        case ({c[1:0], c[15:13]})
            5'b00_000: begin
                r.illegal = (c[12:5] == 8'd0);
                r.instr = pack_i({2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00},
                                 5'd2, 3'd0, rs2p, 7'b0010011);
            end
            5'b00_010: r.instr = pack_i({5'd0, c[5], c[12:10], c[6], 2'b00},
                                        rdp, 3'd2, rs2p, 7'b0000011);
            5'b00_110: r.instr = pack_s({5'd0, c[5], c[12:10], c[6], 2'b00},
                                        rs2p, rdp, 3'd2, 7'b0100011);
            5'b01_000: r.instr = pack_i(ci, rd, 3'd0, rd, 7'b0010011);
            5'b01_001, 5'b01_101: begin
                off = '0;
                off[11]  = c[12];
                off[4]   = c[11];
                off[9:8] = c[10:9];
                off[10]  = c[8];
                off[6]   = c[7];
                off[7]   = c[6];
                off[3:1] = c[5:3];
                off[5]   = c[2];
                r.instr = {off[11], off[10:1], off[11], {8{off[11]}},
                           c[15] ? 5'd0 : 5'd1, 7'b1101111};
            end
            5'b01_010: r.instr = pack_i(ci, 5'd0, 3'd0, rd, 7'b0010011);
            5'b01_011: begin
                if (rd == 5'd2) begin
                    sp16 = {c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
                    r.illegal = (sp16 == 10'd0);
                    r.instr = pack_i({{2{c[12]}}, sp16}, 5'd2, 3'd0, 5'd2, 7'b0010011);
                end else begin
                    r.illegal = (rd == 5'd0) || ({c[12], c[6:2]} == 6'd0);
                    r.instr = {{14{c[12]}}, c[12], c[6:2], rd, 7'b0110111};
                end
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00: r.instr = pack_i({7'd0, c[6:2]}, rdp, 3'd5, rdp, 7'b0010011);
                    2'b01: r.instr = pack_i({7'b0100000, c[6:2]}, rdp, 3'd5, rdp,
                                            7'b0010011);
                    2'b10: r.instr = pack_i(ci, rdp, 3'd7, rdp, 7'b0010011);
                    default: begin
                        f3 = (c[6:5] == 2'b00) ? 3'd0 : (c[6:5] == 2'b01) ? 3'd4 :
                             (c[6:5] == 2'b10) ? 3'd6 : 3'd7;
                        r.instr = pack_r((c[6:5] == 2'b00) ? 7'b0100000 : 7'd0,
                                         rs2p, rdp, f3, rdp);
                    end
                endcase
                // andi keeps bit 12 as its sign while the other forms reserve it
                r.illegal = c[12] && (c[11:10] != 2'b10);
            end
            5'b01_110, 5'b01_111: begin
                boff = '0;
                boff[8]   = c[12];
                boff[4:3] = c[11:10];
                boff[7:6] = c[6:5];
                boff[2:1] = c[4:3];
                boff[5]   = c[2];
                r.instr = {boff[8], {2{boff[8]}}, boff[8:5], 5'd0, rdp, {2'b00, c[13]},
                           boff[4:1], boff[8], 7'b1100011};
            end
            5'b10_000: begin
                r.illegal = c[12];
                r.instr = pack_i({7'd0, c[6:2]}, rd, 3'd1, rd, 7'b0010011);
            end
            5'b10_010: begin
                r.illegal = (rd == 5'd0);
                r.instr = pack_i({4'd0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'd2, rd,
                                 7'b0000011);
            end
            5'b10_110: r.instr = pack_s({4'd0, c[8:7], c[12:9], 2'b00}, rs2, 5'd2, 3'd2,
                                        7'b0100011);
            5'b10_100: begin
                if (rs2 != 5'd0) begin
                    r.instr = pack_r(7'd0, rs2, c[12] ? rd : 5'd0, 3'd0, rd);
                end else begin
                    // rs1 = x0 is reserved for c.jr and is ebreak for c.jalr
                    r.illegal = (rd == 5'd0);
                    r.instr = pack_i(12'd0, rd, 3'd0, {4'd0, c[12]}, 7'b1100111);
                end
            end
            default: r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    // ==================================================
    // stimulus and monitor
    // ==================================================

    always @(negedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles in test %s", cycle, cur_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // the stage is full exactly while a word is outstanding in the model
    always @(negedge clk) begin
        logic exp_valid;
        logic exp_ready;
        exp_valid = (sent_q.size() != 0);
        exp_ready = !exp_valid || ready_i;
        if (rst_n_i) begin
            if (valid_o !== exp_valid) begin
                $display("Mismatch in %s: valid_o expected %b actual %b", cur_name,
                         exp_valid, valid_o);
                hs_err++;
            end
            if (ready_o !== exp_ready) begin
                $display("Mismatch in %s: ready_o expected %b actual %b", cur_name,
                         exp_ready, ready_o);
                hs_err++;
            end
        end
    end

    always @(posedge clk) begin
        rvc_result_t exp_r;
        cinstr_t     w;
        if (rst_n_i) begin
            if (prev_valid && !prev_ready && (!valid_o || result_o !== prev_result)) begin
                $display("%s: output changed while held by back-pressure", cur_name);
                mon_err++;
            end
            if (valid_o && (!prev_valid || prev_ready)) begin
                if (acc_cyc_q.size() == 0) begin
                    $display("%s: valid_o raised with no accepted word", cur_name);
                    mon_err++;
                end else if (acc_cyc_q[0] != cycle - 1) begin
                    $display("Mismatch in %s: latency expected 1 actual %0d", cur_name,
                             cycle - acc_cyc_q[0]);
                    mon_err++;
                end
            end
            if (valid_o && ready_i) begin
                out_cnt++;
                if (sent_q.size() == 0) begin
                    $display("%s: result delivered with no word outstanding", cur_name);
                    mon_err++;
                end else begin
                    w = sent_q.pop_front();
                    void'(acc_cyc_q.pop_front());
                    exp_r = expand_model(w);
                    if (exp_r.illegal && !result_o.illegal) begin
                        $display("Mismatch in %s: word %h expected illegal 1 actual 0",
                                 cur_name, w);
                        mon_err++;
                    end else if (!exp_r.illegal && result_o !== exp_r) begin
                        $display("Mismatch in %s: word %h expected %h/%b actual %h/%b",
                                 cur_name, w, exp_r.instr, exp_r.illegal,
                                 result_o.instr, result_o.illegal);
                        mon_err++;
                    end
                end
            end
        end
        prev_valid  = valid_o;
        prev_ready  = ready_i;
        prev_result = result_o;
    end

    // offers pend_q in order and holds each word until it is taken
    task automatic drive_words(input logic bp);
        logic acc;
        while (pend_q.size() > 0 || valid_i) begin
            @(posedge clk);
            acc = valid_i && ready_o;
            if (acc) begin
                sent_q.push_back(cinstr_i);
                acc_cyc_q.push_back(cycle);
            end
            if (acc || !valid_i) begin
                if (pend_q.size() > 0) begin
                    cinstr_i <= pend_q.pop_front();
                    valid_i  <= 1'b1;
                end else begin
                    valid_i <= 1'b0;
                end
            end
            ready_i <= bp ? rand_bit() : 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n_rand,
                            input logic bp);
        int n_words;
        int err_start;
        int out_start;
        int test_err;
        int i;
        cur_name  = name;
        err_start = error_total();
        out_start = out_cnt;
        for (i = 0; i < n_rand; i++) begin
            pend_q.push_back(gen_word(kind));
        end
        n_words = pend_q.size();
        drive_words(bp);
        ready_i <= 1'b1;
        while (sent_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (out_cnt - out_start != n_words) begin
            $display("Mismatch in %s: result count expected %0d actual %0d", name, n_words,
                     out_cnt - out_start);
            drv_err++;
        end
        test_err = error_total() - err_start;
        if (test_err == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %s: %0d words, %0d errors, %s", name, n_words, test_err,
                 (test_err == 0) ? "ok" : "failed");
    endtask

    initial begin
        rst_n_i  <= 1'b0;
        valid_i  <= 1'b0;
        ready_i  <= 1'b1;
        cinstr_i <= '0;
        repeat (16) @(posedge clk);
        if (valid_o !== 1'b0 || result_o !== '0) begin
            $display("Mismatch in reset: valid_o/result_o expected 0/0 actual %b/%h",
                     valid_o, result_o);
            drv_err++;
        end
        rst_n_i <= 1'b1;

        // addi4spn with zero immediate
        pend_q.push_back(16'h0010);
        run_test("q0", 1, N_Q0, 1'b0);
        // addi16sp with zero immediate and lui to x0
        pend_q.push_back(16'h6101);
        pend_q.push_back(16'h6005);
        run_test("q1_arith", 2, N_Q1A, 1'b0);
        run_test("q1_flow", 3, N_Q1C, 1'b0);
        // lwsp to x0, jr x0 and ebreak
        pend_q.push_back(16'h4006);
        pend_q.push_back(16'h8002);
        pend_q.push_back(16'h9002);
        run_test("q2", 4, N_Q2, 1'b0);
        pend_q.push_back(16'h0000);
        run_test("illegal", 5, N_Q3, 1'b0);
        run_test("backpressure", 6, N_BP, 1'b1);

        $display("tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad,
                 error_total());
        if (tests_bad == 0 && error_total() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
